//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = soc_top_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim.f
verilog/soc_pkg.sv
verilog/mem_arbiter.sv
verilog/addr_decoder.sv
verilog/ram_wrapper.sv
verilog/gpio_regs.sv
verilog/soc_top.sv
test/soc_top_props.sv
test/soc_top_tb.sv

//--- test/soc_top_props.sv
`timescale 1ns/1ps

module soc_top_props (
	input logic                clk_i,
	input logic                reset_i,
	input logic                mem_ready_i,
	input logic                bus_rd_i,
	input logic                bus_wr_i,
	input logic                bus_ready_i
);

// Stall release lasts one cycle
a_ready_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
	mem_ready_i |=> !mem_ready_i)
	else $error("mem_ready_o high two cycles running");

a_strobe_excl: assert property (@(posedge clk_i) disable iff (reset_i)
	!(bus_rd_i && bus_wr_i))
	else $error("bus read and write strobes high together");

// Targets answer exactly one cycle late
a_ready_after_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
	bus_ready_i |-> $past(bus_rd_i || bus_wr_i))
	else $error("bus ready without a strobe in the cycle before");

endmodule

bind mem_arbiter soc_top_props i_soc_top_props (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.mem_ready_i(mem_ready_o),
	.bus_rd_i(bus_rd_o),
	.bus_wr_i(bus_wr_o),
	.bus_ready_i(bus_ready_i)
);

//--- test/soc_top_tb.sv
`timescale 1ns/1ps

module soc_top_tb;

localparam int CLK_PERIOD = 100;
localparam int RESET_CYCLES = 16;
localparam int DRIVE_DELAY = 10;       // Input skew after the rising edge
localparam int FIELDS = 8;             // Words per trace line
localparam int MAX_LINES = 64;
localparam int CYCLES_PER_LINE = 16;
localparam int MARGIN = 50;

// Trace opcodes
localparam logic [31:0] OP_FETCH    = 32'd1;
localparam logic [31:0] OP_READ     = 32'd2;
localparam logic [31:0] OP_WRITE    = 32'd3;
localparam logic [31:0] OP_FETCH_RD = 32'd4;  // Fetch plus data read
localparam logic [31:0] OP_FETCH_WR = 32'd5;  // Fetch plus data write

logic clk, reset;
logic instr_rd, data_rd, data_wr;
soc_pkg::addr_t instr_addr, data_addr;
soc_pkg::word_t data_wdata;
soc_pkg::be_t data_be;
soc_pkg::gpio_t gpio_in, gpio_out;
soc_pkg::word_t instr_data, data_rdata;
logic mem_ready;

logic [31:0] trace_mem [FIELDS*MAX_LINES];
int n_lines, n_checks, n_errors;
int cycle_count, cycle_limit;
logic [31:0] lfsr_q;  // Gap generator state

soc_top i_soc_top (
	.clk_i(clk),
	.reset_i(reset),
	.instr_rd_i(instr_rd),
	.instr_addr_i(instr_addr),
	.instr_data_o(instr_data),
	.data_rd_i(data_rd),
	.data_wr_i(data_wr),
	.data_addr_i(data_addr),
	.data_wdata_i(data_wdata),
	.data_be_i(data_be),
	.data_rdata_o(data_rdata),
	.mem_ready_o(mem_ready),
	.gpio_i(gpio_in),
	.gpio_o(gpio_out)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD/2) clk = ~clk;
end

// Watchdog on the whole run
initial begin
	cycle_count = 0;
	while (cycle_count <= cycle_limit) begin
		@(posedge clk);
		cycle_count++;
	end
	$display("Timeout: run still busy after %0d cycles", cycle_limit);
	$display("Done: errors found");
	$finish;
end

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic random_gap(output int gap);
	gap = 0;
	repeat (2) begin  // Two bits, 0 to 3 cycles
		lfsr_q = lfsr_next(lfsr_q);
		gap = (gap << 1) | int'(lfsr_q[0]);
	end
endtask

task automatic check_word(input string name, input soc_pkg::word_t actual,
		input soc_pkg::word_t expected);
	n_checks++;
	assert (actual === expected)
	else begin
		n_errors++;
		$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
	end
endtask

task automatic idle_inputs();
	instr_rd = 1'b0;
	data_rd = 1'b0;
	data_wr = 1'b0;
	instr_addr = '0;
	data_addr = '0;
	data_wdata = '0;
	data_be = '0;  // gpio_in keeps its last value
endtask

// Sampled at the falling edge, away from the register updates
task automatic wait_ready();
	@(negedge clk);
	while (!mem_ready)
		@(negedge clk);
endtask

task automatic run_line(input int idx);
	logic [31:0] op;
	int base;
	base = idx * FIELDS;
	op = trace_mem[base];
	instr_rd = (op == OP_FETCH || op == OP_FETCH_RD || op == OP_FETCH_WR);
	data_rd = (op == OP_READ || op == OP_FETCH_RD);
	data_wr = (op == OP_WRITE || op == OP_FETCH_WR);
	instr_addr = trace_mem[base + 1];
	data_addr = trace_mem[base + 2];
	data_wdata = trace_mem[base + 3];
	data_be = trace_mem[base + 4][3:0];
	gpio_in = trace_mem[base + 5][7:0];
	wait_ready();
	if (instr_rd)
		check_word("instr_data_o", instr_data, trace_mem[base + 6]);
	if (data_rd)
		check_word("data_rdata_o", data_rdata, trace_mem[base + 7]);
	if (data_wr)
		check_word("gpio_o", {24'h0, gpio_out}, trace_mem[base + 7]);  // Pins after write
	@(posedge clk);  // Drop strobes once DONE is over
	#DRIVE_DELAY;
	idle_inputs();
endtask

initial begin
	int gap;
	n_checks = 0;
	n_errors = 0;
	lfsr_q = 32'hbafb_4049;
	reset = 1'b1;
	gpio_in = '0;
	idle_inputs();
	$readmemh("test/soc_trace.txt", trace_mem);
	n_lines = 0;
	while (n_lines < MAX_LINES && trace_mem[n_lines*FIELDS] inside {[OP_FETCH:OP_FETCH_WR]})
		n_lines++;
	cycle_limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES + MARGIN;
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DELAY reset = 1'b0;
	repeat (2) @(posedge clk);
	#DRIVE_DELAY;
	// Quiet outputs before any request
	check_word("mem_ready_o", {31'h0, mem_ready}, 32'h0);
	check_word("gpio_o", {24'h0, gpio_out}, 32'h0);
	for (int i = 0; i < n_lines; i++) begin
		run_line(i);
		random_gap(gap);
		repeat (gap) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	end
	$display("Lines: %0d, checks: %0d, errors: %0d", n_lines, n_checks, n_errors);
	if (n_errors == 0)
		$display("Done: no errors");
	else
		$display("Done: errors found");
	$finish;
end

endmodule

//--- test/soc_trace.txt
// op iaddr daddr wdata be gpio_i exp_instr exp_data (exp_data is gpio_o on writes)
// op: 1 fetch, 2 read, 3 write, 4 fetch+read, 5 fetch+write
3 00000000 00060000 11223344 f 00 00000000 00000000
3 00000000 00060004 a5a5a5a5 f 00 00000000 00000000
2 00000000 00060000 00000000 f 00 00000000 11223344
2 00000000 00060004 00000000 f 00 00000000 a5a5a5a5
3 00000000 00060000 deadbeef 1 00 00000000 00000000
3 00000000 00060000 cafef00d 6 00 00000000 00000000
2 00000000 00060000 00000000 f 00 00000000 11fef0ef
3 00000000 00060004 00990000 c 00 00000000 00000000
2 00000000 00060004 00000000 f 00 00000000 0099a5a5
3 00000000 00060008 00000013 f 00 00000000 00000000
1 00060008 00000000 00000000 0 00 00000013 00000000
4 00060000 00060004 00000000 f 00 11fef0ef 0099a5a5
5 00060004 0006000c 76543210 f 00 0099a5a5 00000000
2 00000000 0006000c 00000000 f 00 00000000 76543210
3 00000000 00000000 123456c3 f 00 00000000 000000c3
2 00000000 00000000 00000000 f 00 00000000 000000c3
3 00000000 00000000 000000ff e 5a 00000000 000000c3
2 00000000 00000004 00000000 f 5a 00000000 0000005a
3 00000000 00000000 0000007e 1 a6 00000000 0000007e
2 00000000 00000004 00000000 f a6 00000000 000000a6
2 00000000 00020000 00000000 f a6 00000000 00000000
3 00000000 00020000 ffffffff f a6 00000000 0000007e
3 00000000 80000000 ffffffff f a6 00000000 0000007e
2 00000000 00060000 00000000 f a6 00000000 11fef0ef
4 00000004 00060008 00000000 f a6 000000a6 00000013
2 00000000 80000000 00000000 f a6 00000000 00000000

//--- verilog/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder (
	input  logic            clk_i,
	input  logic            reset_i,
	// From the arbiter
	input  logic            bus_rd_i,
	input  logic            bus_wr_i,
	input  soc_pkg::addr_t  bus_addr_i,
	output logic            bus_ready_o,
	output soc_pkg::word_t  bus_rdata_o,
	// RAM target
	output logic            ram_rd_o,
	output logic            ram_wr_o,
	input  logic            ram_ready_i,
	input  soc_pkg::word_t  ram_rdata_i,
	// GPIO target
	output logic            gpio_rd_o,
	output logic            gpio_wr_o,
	input  logic            gpio_ready_i,
	input  soc_pkg::word_t  gpio_rdata_i
);

soc_pkg::region_t region_s;
logic hit_ram_s, hit_gpio_s;
logic unmapped_s;
logic unmapped_ready_q;  // Stand-in ready for holes in the map

assign region_s = bus_addr_i[31:soc_pkg::REGION_LSB];
assign hit_ram_s = (region_s == soc_pkg::REGION_RAM);
assign hit_gpio_s = (region_s == soc_pkg::REGION_GPIO);
assign unmapped_s = (bus_rd_i | bus_wr_i) & ~hit_ram_s & ~hit_gpio_s;

// Strobe goes to one target at most
assign ram_rd_o  = bus_rd_i & hit_ram_s;
assign ram_wr_o  = bus_wr_i & hit_ram_s;
assign gpio_rd_o = bus_rd_i & hit_gpio_s;
assign gpio_wr_o = bus_wr_i & hit_gpio_s;

always_ff @(posedge clk_i) begin
	if (reset_i)
		unmapped_ready_q <= 1'b0;
	else
		unmapped_ready_q <= unmapped_s;  // Same one-cycle latency as a target
end

assign bus_ready_o = ram_ready_i | gpio_ready_i | unmapped_ready_q;

// Only the answering target drives data, zero otherwise
assign bus_rdata_o = ram_ready_i  ? ram_rdata_i  :
                     gpio_ready_i ? gpio_rdata_i : '0;

endmodule

//--- verilog/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
	input  logic            clk_i,
	input  logic            reset_i,
	input  logic            read_i,
	input  logic            write_i,
	input  logic            reg_sel_i,      // Address bit 2
	input  soc_pkg::word_t  data_i,
	input  soc_pkg::be_t    byte_select_i,
	output logic            ready_o,
	output soc_pkg::word_t  data_o,
	// Pins
	input  soc_pkg::gpio_t  gpio_i,
	output soc_pkg::gpio_t  gpio_o
);

localparam int PAD_W = $bits(soc_pkg::word_t) - soc_pkg::GPIO_W;

soc_pkg::gpio_t out_q;   // Output register
soc_pkg::gpio_t meta_q;  // First sync stage
soc_pkg::gpio_t in_q;    // Input register, second stage
logic wr_out_s;

// Lane 0 only, input register is read-only
assign wr_out_s = write_i && reg_sel_i == soc_pkg::GPIO_OUT_OFS && byte_select_i[0];

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		out_q   <= '0;
		meta_q  <= '0;
		in_q    <= '0;
		ready_o <= 1'b0;
	end else begin
		if (wr_out_s)
			out_q <= data_i[soc_pkg::GPIO_W-1:0];
		meta_q  <= gpio_i;   // Pins are asynchronous
		in_q    <= meta_q;
		ready_o <= read_i | write_i;
	end
end

assign gpio_o = out_q;

// Read mux, zero-extended to a word
always_ff @(posedge clk_i) begin
	if (read_i)
		data_o <= (reg_sel_i == soc_pkg::GPIO_IN_OFS) ? {{PAD_W{1'b0}}, in_q}
		                                              : {{PAD_W{1'b0}}, out_q};
end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic            clk_i,
	input  logic            reset_i,
	// Instruction port
	input  logic            instr_rd_i,
	input  soc_pkg::addr_t  instr_addr_i,
	// Data port
	input  logic            data_rd_i,
	input  logic            data_wr_i,
	input  soc_pkg::addr_t  data_addr_i,
	input  soc_pkg::word_t  data_wdata_i,
	input  soc_pkg::be_t    data_be_i,
	// Back to the processor
	output soc_pkg::word_t  instr_data_o,
	output soc_pkg::word_t  data_rdata_o,
	output logic            mem_ready_o,
	// Shared bus
	output logic            bus_rd_o,
	output logic            bus_wr_o,
	output soc_pkg::addr_t  bus_addr_o,
	output soc_pkg::word_t  bus_wdata_o,
	output soc_pkg::be_t    bus_be_o,
	input  logic            bus_ready_i,
	input  soc_pkg::word_t  bus_rdata_i
);

soc_pkg::arb_state_t state_q, state_d;
logic want_data_q;  // Data access pending after the fetch
logic data_wr_q;    // Data access is a write
logic issued_q;     // Strobe sent, waiting for ready
logic req_s;
logic strobe_s;
logic done_s;       // Current access answered

assign req_s = instr_rd_i | data_rd_i | data_wr_i;
assign done_s = issued_q & bus_ready_i;

// One strobe cycle at the start of each access
assign strobe_s = (state_q == soc_pkg::INSTR || state_q == soc_pkg::DATA) && !issued_q;

assign bus_rd_o = strobe_s && (state_q == soc_pkg::INSTR || !data_wr_q);
assign bus_wr_o = strobe_s && state_q == soc_pkg::DATA && data_wr_q;
assign bus_addr_o = (state_q == soc_pkg::INSTR) ? instr_addr_i : data_addr_i;
assign bus_wdata_o = data_wdata_i;  // Held steady by the requester
assign bus_be_o = (state_q == soc_pkg::INSTR) ? '1 : data_be_i;  // Fetch is a full word

assign mem_ready_o = (state_q == soc_pkg::DONE);  // Stall release

always_comb begin
	state_d = state_q;
	case (state_q)
		soc_pkg::IDLE: begin
			if (req_s)
				state_d = instr_rd_i ? soc_pkg::INSTR : soc_pkg::DATA;  // Fetch goes first
		end
		soc_pkg::INSTR: begin
			if (done_s)
				state_d = want_data_q ? soc_pkg::DATA : soc_pkg::DONE;
		end
		soc_pkg::DATA: begin
			if (done_s)
				state_d = soc_pkg::DONE;
		end
		default: state_d = soc_pkg::IDLE;  // DONE lasts one cycle, strobes ignored
	endcase
end

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		state_q     <= soc_pkg::IDLE;
		want_data_q <= 1'b0;
		data_wr_q   <= 1'b0;
		issued_q    <= 1'b0;
	end else begin
		state_q <= state_d;
		// Snapshot of the request mix
		if (state_q == soc_pkg::IDLE && req_s) begin
			want_data_q <= data_rd_i | data_wr_i;
			data_wr_q   <= data_wr_i;
		end
		if (strobe_s)
			issued_q <= 1'b1;
		else if (bus_ready_i)
			issued_q <= 1'b0;
	end
end

// Read data held until the next access of the same kind
always_ff @(posedge clk_i) begin
	if (done_s) begin
		if (state_q == soc_pkg::INSTR)
			instr_data_o <= bus_rdata_i;
		else if (!data_wr_q)
			data_rdata_o <= bus_rdata_i;  // Writes leave it alone
	end
end

endmodule

//--- verilog/ram_wrapper.sv
`timescale 1ns/1ps

module ram_wrapper (
	input  logic                       clk_i,
	input  logic                       reset_i,
	input  logic                       read_i,
	input  logic                       write_i,
	input  logic [soc_pkg::RAM_AW-1:0] addr_i,         // Word address
	input  soc_pkg::word_t             data_i,
	input  soc_pkg::be_t               byte_select_i,  // Lane enables
	output logic                       mem_ready_o,
	output soc_pkg::word_t             data_o
);

localparam int DEPTH = 2 ** soc_pkg::RAM_AW;
localparam int LANES = $bits(soc_pkg::be_t);

soc_pkg::word_t mem [DEPTH];  // Contents undefined after reset

// Lane-wise write
always_ff @(posedge clk_i) begin
	for (int i = 0; i < LANES; i++) begin
		if (write_i && byte_select_i[i])
			mem[addr_i][i*8 +: 8] <= data_i[i*8 +: 8];
	end
end

// Registered read
always_ff @(posedge clk_i) begin
	if (read_i)
		data_o <= mem[addr_i];
end

// Ready one cycle after any strobe
always_ff @(posedge clk_i) begin
	if (reset_i)
		mem_ready_o <= 1'b0;
	else
		mem_ready_o <= read_i | write_i;
end

endmodule

//--- verilog/soc_pkg.sv
package soc_pkg;

	// Bus widths
	typedef logic [31:0] addr_t;  // Byte address
	typedef logic [31:0] word_t;  // Data word
	typedef logic [3:0]  be_t;    // One bit per byte lane

	// Region field sits in the top 15 address bits
	localparam int REGION_LSB = 17;
	typedef logic [31-REGION_LSB:0] region_t;

	// Region map
	localparam region_t REGION_GPIO = 15'd0;  // Former UART slot
	localparam region_t REGION_RAM  = 15'd3;

	// RAM word address, byte address bits 16 to 2
	localparam int RAM_AW = 15;

	// GPIO block
	localparam int GPIO_W = 8;
	typedef logic [GPIO_W-1:0] gpio_t;

	// Register select, byte address bit 2
	localparam logic GPIO_OUT_OFS = 1'b0;  // Output register
	localparam logic GPIO_IN_OFS  = 1'b1;  // Synchronised input register

	// Arbiter FSM
	typedef enum logic [1:0] {
		IDLE,   // Waiting for a request
		INSTR,  // Instruction fetch on the bus
		DATA,   // Data access on the bus
		DONE    // Ready pulse to the processor
	} arb_state_t;

endpackage

//--- verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top (
	input  logic            clk_i,
	input  logic            reset_i,
	// Instruction port
	input  logic            instr_rd_i,
	input  soc_pkg::addr_t  instr_addr_i,
	output soc_pkg::word_t  instr_data_o,
	// Data port
	input  logic            data_rd_i,
	input  logic            data_wr_i,
	input  soc_pkg::addr_t  data_addr_i,
	input  soc_pkg::word_t  data_wdata_i,
	input  soc_pkg::be_t    data_be_i,
	output soc_pkg::word_t  data_rdata_o,
	// Processor stall
	output logic            mem_ready_o,
	// Pins
	input  soc_pkg::gpio_t  gpio_i,
	output soc_pkg::gpio_t  gpio_o
);

// Shared bus
logic bus_rd_s, bus_wr_s, bus_ready_s;
soc_pkg::addr_t bus_addr_s;
soc_pkg::word_t bus_wdata_s, bus_rdata_s;
soc_pkg::be_t bus_be_s;
// Targets
logic ram_rd_s, ram_wr_s, ram_ready_s;
soc_pkg::word_t ram_rdata_s;
logic gpio_rd_s, gpio_wr_s, gpio_ready_s;
soc_pkg::word_t gpio_rdata_s;

mem_arbiter inst_mem_arbiter (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.instr_rd_i(instr_rd_i),
	.instr_addr_i(instr_addr_i),
	.data_rd_i(data_rd_i),
	.data_wr_i(data_wr_i),
	.data_addr_i(data_addr_i),
	.data_wdata_i(data_wdata_i),
	.data_be_i(data_be_i),
	.instr_data_o(instr_data_o),
	.data_rdata_o(data_rdata_o),
	.mem_ready_o(mem_ready_o),
	.bus_rd_o(bus_rd_s),
	.bus_wr_o(bus_wr_s),
	.bus_addr_o(bus_addr_s),
	.bus_wdata_o(bus_wdata_s),
	.bus_be_o(bus_be_s),
	.bus_ready_i(bus_ready_s),
	.bus_rdata_i(bus_rdata_s)
);

addr_decoder inst_addr_decoder (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.bus_rd_i(bus_rd_s),
	.bus_wr_i(bus_wr_s),
	.bus_addr_i(bus_addr_s),
	.bus_ready_o(bus_ready_s),
	.bus_rdata_o(bus_rdata_s),
	.ram_rd_o(ram_rd_s),
	.ram_wr_o(ram_wr_s),
	.ram_ready_i(ram_ready_s),
	.ram_rdata_i(ram_rdata_s),
	.gpio_rd_o(gpio_rd_s),
	.gpio_wr_o(gpio_wr_s),
	.gpio_ready_i(gpio_ready_s),
	.gpio_rdata_i(gpio_rdata_s)
);

ram_wrapper inst_ram_wrapper (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.read_i(ram_rd_s),
	.write_i(ram_wr_s),
	.addr_i(bus_addr_s[16:2]),  // Word address inside the region
	.data_i(bus_wdata_s),
	.byte_select_i(bus_be_s),
	.mem_ready_o(ram_ready_s),
	.data_o(ram_rdata_s)
);

gpio_regs inst_gpio_regs (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.read_i(gpio_rd_s),
	.write_i(gpio_wr_s),
	.reg_sel_i(bus_addr_s[2]),
	.data_i(bus_wdata_s),
	.byte_select_i(bus_be_s),
	.ready_o(gpio_ready_s),
	.data_o(gpio_rdata_s),
	.gpio_i(gpio_i),
	.gpio_o(gpio_o)
);

endmodule
